// ==== logic/fdc_bus_pkg.sv ====
// ------------------------------------------------
// fdc bus package
// CPU-side address map, device type codes and the
// widths of the 8-bit peripheral bus
// ------------------------------------------------
`default_nettype none

package fdc_bus_pkg;

   typedef logic [13:0] cpu_addr_t;   // offset inside the device window
   typedef logic [7:0]  cpu_data_t;
   typedef logic [3:0]  dev_typ_t;

   localparam dev_typ_t DEV_VY0010 = 4'h4;

   // ------------------------------------------------
   // register map, top of the window
   localparam cpu_addr_t FDC_WD_BASE     = 14'h3FF8;   // cmd/status, track, sector, data
   localparam cpu_addr_t FDC_SIDE_ADDR   = 14'h3FFC;
   localparam cpu_addr_t FDC_DRIVE_ADDR  = 14'h3FFD;
   localparam cpu_addr_t FDC_UNUSED_ADDR = 14'h3FFE;
   localparam cpu_addr_t FDC_STATUS_ADDR = 14'h3FFF;

   localparam cpu_data_t DRIVE_READ_MASK = 8'hFB;   // bit 2 reads back as zero

endpackage

`default_nettype wire

// ==== logic/fdc_disk_pkg.sv ====
// ------------------------------------------------
// fdc disk package
// geometry types, WD command codes, status bit
// positions and the controller state encoding
// ------------------------------------------------
`default_nettype none

package fdc_disk_pkg;

   typedef logic [7:0]  track_t;
   typedef logic [7:0]  sector_t;
   typedef logic [31:0] lba_t;
   typedef logic [8:0]  buf_addr_t;   // byte index in a 512-byte sector
   typedef logic [31:0] img_size_t;

   // images above this size hold both sides
   localparam img_size_t LAYOUT_LIMIT = 32'h0005_A000;

   // upper nibble of the command byte
   localparam logic [3:0] CMD_RESTORE = 4'h0;
   localparam logic [3:0] CMD_SEEK    = 4'h1;
   localparam logic [3:0] CMD_READ    = 4'h8;

   // status register bits
   localparam int ST_BUSY   = 0;
   localparam int ST_DRQ    = 1;
   localparam int ST_RNF    = 4;
   localparam int ST_WPROT  = 6;
   localparam int ST_NOTRDY = 7;

   typedef enum logic [1:0] {IDLE, SD_REQ, SD_FILL, XFER} fdc_state_e;

endpackage

`default_nettype wire

// ==== logic/fdc_reg_decode.sv ====
// ------------------------------------------------
// fdc register decode
// chip select, window address decode, side and
// drive registers, latching of the mounted image
// (presence, layout, write protect) and ready
// ------------------------------------------------
`default_nettype none

module fdc_reg_decode
   import fdc_bus_pkg::*;
   import fdc_disk_pkg::*;
#(
   parameter int DEV_NUM = 0
) (
   input  wire logic      cpu_bus,
   input  wire logic      rst_n,
   input  wire cpu_addr_t addr,
   input  wire cpu_data_t wr_data,
   input  wire logic      wr,
   input  wire dev_typ_t  dev_typ,
   input  wire logic [3:0] dev_num,
   input  wire logic      img_mounted,
   input  wire img_size_t img_size,
   input  wire logic      img_readonly,
   output logic           wd_sel,
   output logic [1:0]     wd_reg,
   output logic           cs_any,
   output logic           sel_side,
   output logic           sel_drive,
   output logic           sel_unused,
   output logic           sel_status,
   output cpu_data_t      side_q,
   output cpu_data_t      drive_q,
   output logic           side,
   output logic           ready,
   output logic           layout,
   output logic           wprot
);

   logic cs;
   logic mounted;   // image present and non-empty

   assign cs = (dev_typ == DEV_VY0010) && (dev_num == 4'(DEV_NUM));

   assign wd_sel     = cs && (addr[13:2] == FDC_WD_BASE[13:2]);
   assign wd_reg     = addr[1:0];
   assign sel_side   = cs && (addr == FDC_SIDE_ADDR);
   assign sel_drive  = cs && (addr == FDC_DRIVE_ADDR);
   assign sel_unused = cs && (addr == FDC_UNUSED_ADDR);
   assign sel_status = cs && (addr == FDC_STATUS_ADDR);
   assign cs_any     = wd_sel | sel_side | sel_drive | sel_unused | sel_status;

   // ------------------------------------------------
   // side and drive registers
   always_ff @(posedge cpu_bus or negedge rst_n) begin
      if (!rst_n) begin
         side_q  <= '0;
         drive_q <= '0;
      end else begin
         if (sel_side && wr)  side_q  <= wr_data;
         if (sel_drive && wr) drive_q <= wr_data;
      end
   end

   // image info, sampled on the mount strobe
   always_ff @(posedge cpu_bus or negedge rst_n) begin
      if (!rst_n) begin
         mounted <= 1'b0;
         layout  <= 1'b0;
         wprot   <= 1'b0;
      end else if (img_mounted) begin
         mounted <= (img_size != '0);
         layout  <= (img_size > LAYOUT_LIMIT) ? 1'b0 : 1'b1;   // 1 = single sided
         wprot   <= img_readonly;
      end
   end

   assign side  = side_q[0];
   assign ready = mounted & drive_q[7] & ~drive_q[0];   // motor on, drive not parked

endmodule

`default_nettype wire

// ==== logic/fdc_sector_engine.sv ====
// ------------------------------------------------
// fdc sector engine
// WD1793-style controller with restore, seek and
// single-sector read. Fetches the sector from the
// SD image into a local buffer and hands it to the
// CPU byte by byte under DRQ
// ------------------------------------------------
`default_nettype none

module fdc_sector_engine
   import fdc_disk_pkg::*;
   import fdc_bus_pkg::*;
#(
   parameter int SECTORS_PER_TRACK = 9
) (
   input  wire logic      cpu_bus,
   input  wire logic      rst_n,
   input  wire logic      wd_sel,
   input  wire logic [1:0] wd_reg,
   input  wire logic      rd,
   input  wire logic      wr,
   input  wire cpu_data_t wr_data,
   input  wire logic      side,
   input  wire logic      ready,
   input  wire logic      layout,
   input  wire logic      wprot,
   input  wire logic      sd_ack,
   input  wire buf_addr_t sd_buff_addr,
   input  wire cpu_data_t sd_buff_data,
   input  wire logic      sd_buff_wr,
   output cpu_data_t      wd_rdata,
   output logic           drq,
   output logic           intrq,
   output lba_t           sd_lba,
   output logic           sd_rd
);

   fdc_state_e state;
   track_t     track_q;
   sector_t    sector_q;
   cpu_data_t  data_q;
   cpu_data_t  status;
   logic       busy;
   logic       rnf;
   logic       ack_q;
   buf_addr_t  byte_idx;
   buf_addr_t  byte_nxt;
   lba_t       trk_lin;
   lba_t       lba_next;
   logic       reg_wr;
   logic       cmd_wr;
   logic       stat_rd;
   logic       fill_done;
   logic       xfer_rd;

   cpu_data_t  sect_buf [512];

   assign reg_wr    = wd_sel && wr;
   assign cmd_wr    = reg_wr && (wd_reg == 2'd0) && !busy;
   assign stat_rd   = wd_sel && rd && (wd_reg == 2'd0);
   assign fill_done = (state == SD_FILL) && ack_q && !sd_ack;   // falling edge of ack
   assign xfer_rd   = (state == XFER) && wd_sel && rd && (wd_reg == 2'd3);
   assign byte_nxt  = byte_idx + 1'b1;

   // ------------------------------------------------
   // sector address from track, side and sector
   always_comb begin
      if (layout)
         trk_lin = lba_t'(track_q);
      else
         trk_lin = (lba_t'(track_q) << 1) + lba_t'(side);
      lba_next = trk_lin * lba_t'(SECTORS_PER_TRACK) + lba_t'(sector_q) - 32'd1;
   end

   // ------------------------------------------------
   // command FSM
   always_ff @(posedge cpu_bus or negedge rst_n) begin
      if (!rst_n) begin
         state    <= IDLE;
         track_q  <= '0;
         sector_q <= '0;
         busy     <= 1'b0;
         rnf      <= 1'b0;
         drq      <= 1'b0;
         intrq    <= 1'b0;
         sd_rd    <= 1'b0;
         sd_lba   <= '0;
         byte_idx <= '0;
         ack_q    <= 1'b0;
      end else begin
         ack_q <= sd_ack;
         if (stat_rd) intrq <= 1'b0;
         if (reg_wr && (wd_reg == 2'd1) && !busy) track_q  <= wr_data;
         if (reg_wr && (wd_reg == 2'd2) && !busy) sector_q <= wr_data;

         case (state)
            IDLE: begin
               if (cmd_wr) begin
                  rnf   <= 1'b0;
                  intrq <= 1'b1;   // type I and rejected reads finish at once
                  case (wr_data[7:4])
                     CMD_RESTORE: track_q <= '0;
                     CMD_SEEK:    track_q <= data_q;
                     CMD_READ: begin
                        if (!ready) begin
                           // NOTRDY shows live in status
                        end else if (sector_q == '0 ||
                                     sector_q > sector_t'(SECTORS_PER_TRACK)) begin
                           rnf <= 1'b1;
                        end else begin
                           intrq  <= 1'b0;
                           busy   <= 1'b1;
                           sd_rd  <= 1'b1;
                           sd_lba <= lba_next;
                           state  <= SD_REQ;
                        end
                     end
                     default: ;   // unsupported, just complete
                  endcase
               end
            end
            SD_REQ: begin
               if (sd_ack) begin
                  sd_rd <= 1'b0;
                  state <= SD_FILL;
               end
            end
            SD_FILL: begin
               if (fill_done) begin
                  drq      <= 1'b1;
                  byte_idx <= '0;
                  state    <= XFER;
               end
            end
            XFER: begin
               if (xfer_rd) begin
                  if (byte_idx == 9'd511) begin   // last byte taken
                     drq   <= 1'b0;
                     busy  <= 1'b0;
                     intrq <= 1'b1;
                     state <= IDLE;
                  end else begin
                     byte_idx <= byte_nxt;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // sector buffer, filled by the card while ack is up
   always_ff @(posedge cpu_bus) begin
      if (sd_ack && sd_buff_wr) sect_buf[sd_buff_addr] <= sd_buff_data;
   end

   // data register, prefetches the next byte during a transfer
   always_ff @(posedge cpu_bus) begin
      if (fill_done)
         data_q <= sect_buf[0];
      else if (xfer_rd)
         data_q <= sect_buf[byte_nxt];
      else if (reg_wr && (wd_reg == 2'd3) && (state != XFER))
         data_q <= wr_data;
   end

   always_comb begin
      status            = '0;
      status[ST_BUSY]   = busy;
      status[ST_DRQ]    = drq;
      status[ST_RNF]    = rnf;
      status[ST_WPROT]  = wprot;
      status[ST_NOTRDY] = ~ready;
   end

   always_comb begin
      case (wd_reg)
         2'd0:    wd_rdata = status;
         2'd1:    wd_rdata = track_q;
         2'd2:    wd_rdata = sector_q;
         default: wd_rdata = data_q;
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/fdc_read_mux.sv ====
// ------------------------------------------------
// fdc read mux
// read data and output request towards the CPU
// ------------------------------------------------
`default_nettype none

module fdc_read_mux
   import fdc_bus_pkg::*;
(
   input  wire logic      rd,
   input  wire logic      cs_any,
   input  wire logic      wd_sel,
   input  wire logic      sel_side,
   input  wire logic      sel_drive,
   input  wire logic      sel_unused,
   input  wire logic      sel_status,
   input  wire cpu_data_t side_q,
   input  wire cpu_data_t drive_q,
   input  wire cpu_data_t wd_rdata,
   input  wire logic      drq,
   input  wire logic      intrq,
   output cpu_data_t      data,
   output logic           output_rq
);

   always_comb begin
      if (sel_status)
         data = {~drq, ~intrq, 6'b111111};   // both lines active low
      else if (sel_side)
         data = side_q;
      else if (sel_drive)
         data = drive_q & DRIVE_READ_MASK;
      else if (wd_sel)
         data = wd_rdata;
      else if (sel_unused)
         data = 8'hFF;
      else
         data = 8'hFF;   // not ours, bus floats high
   end

   assign output_rq = cs_any & rd;

endmodule

`default_nettype wire

// ==== logic/vy0010_fdc.sv ====
// ------------------------------------------------
// vy0010 floppy controller, top level
// decode, sector engine and read mux on the
// 8-bit CPU bus with an SD block backend
// ------------------------------------------------
`default_nettype none

module vy0010_fdc
   import fdc_bus_pkg::*;
   import fdc_disk_pkg::*;
#(
   parameter int DEV_NUM           = 0,
   parameter int SECTORS_PER_TRACK = 9
) (
   input  wire logic      cpu_bus,
   input  wire logic      rst_n,
   input  wire cpu_addr_t addr,
   input  wire cpu_data_t wr_data,
   input  wire logic      rd,
   input  wire logic      wr,
   input  wire dev_typ_t  dev_typ,
   input  wire logic [3:0] dev_num,
   input  wire logic      img_mounted,
   input  wire img_size_t img_size,
   input  wire logic      img_readonly,
   input  wire logic      sd_ack,
   input  wire buf_addr_t sd_buff_addr,
   input  wire cpu_data_t sd_buff_data,
   input  wire logic      sd_buff_wr,
   output cpu_data_t      data,
   output logic           output_rq,
   output lba_t           sd_lba,
   output logic           sd_rd
);

   logic       wd_sel;
   logic [1:0] wd_reg;
   logic       cs_any;
   logic       sel_side;
   logic       sel_drive;
   logic       sel_unused;
   logic       sel_status;
   cpu_data_t  side_q;
   cpu_data_t  drive_q;
   logic       side;
   logic       ready;
   logic       layout;
   logic       wprot;
   cpu_data_t  wd_rdata;
   logic       drq;
   logic       intrq;

   fdc_reg_decode #(.DEV_NUM(DEV_NUM)) fdc_reg_decode_inst (
      .cpu_bus, .rst_n, .addr, .wr_data, .wr, .dev_typ, .dev_num,
      .img_mounted, .img_size, .img_readonly,
      .wd_sel, .wd_reg, .cs_any, .sel_side, .sel_drive, .sel_unused, .sel_status,
      .side_q, .drive_q, .side, .ready, .layout, .wprot
   );

   fdc_sector_engine #(.SECTORS_PER_TRACK(SECTORS_PER_TRACK)) fdc_sector_engine_inst (
      .cpu_bus, .rst_n, .wd_sel, .wd_reg, .rd, .wr, .wr_data,
      .side, .ready, .layout, .wprot,
      .sd_ack, .sd_buff_addr, .sd_buff_data, .sd_buff_wr,
      .wd_rdata, .drq, .intrq, .sd_lba, .sd_rd
   );

   fdc_read_mux fdc_read_mux_inst (
      .rd, .cs_any, .wd_sel, .sel_side, .sel_drive, .sel_unused, .sel_status,
      .side_q, .drive_q, .wd_rdata, .drq, .intrq,
      .data, .output_rq
   );

endmodule

`default_nettype wire

// ==== testbench/vy0010_fdc_checker.sv ====
// --------------------------------------------------
// vy0010 fdc protocol checker
// SD request and DRQ/INTRQ rules of the sector
// engine, bound into every engine instance
// --------------------------------------------------
`default_nettype none

module vy0010_fdc_checker (
   input wire logic cpu_bus,
   input wire logic rst_n,
   input wire logic sd_rd,
   input wire logic sd_ack,
   input wire logic drq,
   input wire logic intrq
);

   int fail_count = 0;

   rd_drq_apart: assert property (@(posedge cpu_bus) disable iff (!rst_n) !(sd_rd && drq))
      else begin
         $error("sd_rd and drq high together");
         fail_count++;
      end

   drq_intrq_apart: assert property (@(posedge cpu_bus) disable iff (!rst_n) !(drq && intrq))
      else begin
         $error("drq and intrq high together");
         fail_count++;
      end

   // request level holds until the card answers
   rd_held: assert property (@(posedge cpu_bus) disable iff (!rst_n)
                             (sd_rd && !sd_ack) |=> sd_rd)
      else begin
         $error("sd_rd dropped before sd_ack");
         fail_count++;
      end

endmodule

bind fdc_sector_engine vy0010_fdc_checker checker_inst (
   .cpu_bus, .rst_n, .sd_rd, .sd_ack, .drq, .intrq
);

`default_nettype wire

// ==== testbench/vy0010_fdc_tb.sv ====
// --------------------------------------------------
// vy0010 floppy controller testbench
// random register, seek and sector-read traffic
// against a reference model, with an SD card model
// that serves 512-byte blocks
// --------------------------------------------------
`default_nettype none

module vy0010_fdc_tb
   import fdc_bus_pkg::*;
   import fdc_disk_pkg::*;
();

   localparam int DEV_NUM         = 3;
   localparam int SPT             = 9;
   localparam int READS_PER_IMAGE = 8;
   // one sector read is ~1050 cycles, card fill plus 512 CPU reads
   localparam int MAX_CYCLES      = 2 * READS_PER_IMAGE * 1100 + 2000;

   logic       cpu_bus;
   logic       rst_n;
   cpu_addr_t  addr;
   cpu_data_t  wr_data;
   logic       rd;
   logic       wr;
   dev_typ_t   dev_typ;
   logic [3:0] dev_num;
   logic       img_mounted;
   img_size_t  img_size;
   logic       img_readonly;
   logic       sd_ack;
   buf_addr_t  sd_buff_addr;
   cpu_data_t  sd_buff_data;
   logic       sd_buff_wr;
   cpu_data_t  data;
   logic       output_rq;
   lba_t       sd_lba;
   logic       sd_rd;

   integer     seed = 25;
   int         err_count = 0;
   int         pass_tests = 0;
   int         fail_tests = 0;
   int         cycle_count = 0;
   logic       last_rq;

   // --------------------------------------------------
   // reference model state
   cpu_data_t  side_m = '0;
   cpu_data_t  drive_m = '0;
   logic       mounted_m = 1'b0;
   logic       layout_m = 1'b0;
   logic       wprot_m = 1'b0;
   logic       rnf_m = 1'b0;
   cpu_data_t  exp_buf [512];

   vy0010_fdc #(.DEV_NUM(DEV_NUM), .SECTORS_PER_TRACK(SPT)) vy0010_fdc_inst (
      .cpu_bus, .rst_n, .addr, .wr_data, .rd, .wr, .dev_typ, .dev_num,
      .img_mounted, .img_size, .img_readonly,
      .sd_ack, .sd_buff_addr, .sd_buff_data, .sd_buff_wr,
      .data, .output_rq, .sd_lba, .sd_rd
   );

   initial begin
      cpu_bus = 1'b0;
      forever #20 cpu_bus = ~cpu_bus;
   end

   initial begin
      while (cycle_count < MAX_CYCLES) begin
         @(posedge cpu_bus);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      err_count++;
   endtask

   task automatic report_problem(input string what);
      $display("Failure at %0t: %s", $time, what);
      err_count++;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         pass_tests++;
         $display("%s: passed", name);
      end else begin
         fail_tests++;
         $display("%s: FAILED with %0d errors", name, err_count - errs_before);
      end
   endtask

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // status as the WD register should show it between commands
   function automatic cpu_data_t exp_status();
      cpu_data_t s;
      s            = '0;
      s[ST_RNF]    = rnf_m;
      s[ST_WPROT]  = wprot_m;
      s[ST_NOTRDY] = !(mounted_m && drive_m[7] && !drive_m[0]);
      return s;
   endfunction

   // every task starts and ends 2 units after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge cpu_bus);
      #2;
   endtask

   task automatic bus_access(input logic is_wr, input cpu_addr_t a, input cpu_data_t d,
                             output cpu_data_t q);
      addr    = a;
      wr_data = d;
      wr      = is_wr;
      rd      = !is_wr;
      #20;
      q       = data;   // mid-cycle sample
      last_rq = output_rq;
      wait_cycles(1);
      rd = 1'b0;
      wr = 1'b0;
   endtask

   task automatic bus_write(input cpu_addr_t a, input cpu_data_t d);
      cpu_data_t dummy;
      bus_access(1'b1, a, d, dummy);
   endtask

   task automatic bus_read(input cpu_addr_t a, output cpu_data_t q);
      bus_access(1'b0, a, 8'h00, q);
   endtask

   task automatic set_drive(input cpu_data_t d);
      bus_write(FDC_DRIVE_ADDR, d);
      drive_m = d;
   endtask

   task automatic mount_image(input img_size_t size, input logic ro);
      img_size     = size;
      img_readonly = ro;
      img_mounted  = 1'b1;
      wait_cycles(1);
      img_mounted  = 1'b0;
      mounted_m    = (size != 0);
      layout_m     = (size <= LAYOUT_LIMIT);   // 1 = single sided
      wprot_m      = ro;
   endtask

   // --------------------------------------------------
   // SD card model
   task automatic serve_sd_block(input lba_t exp_lba);
      int i;
      i = 0;
      while (!sd_rd && i < 20) begin
         wait_cycles(1);
         i++;
      end
      if (!sd_rd) begin
         report_problem("card never saw an sd_rd request");
      end else begin
         if (sd_lba !== exp_lba) report_mismatch("sd_lba", sd_lba, exp_lba);
         sd_ack = 1'b1;
         wait_cycles(1);
         for (i = 0; i < 512; i++) begin
            sd_buff_wr   = 1'b1;
            sd_buff_addr = buf_addr_t'(i);
            sd_buff_data = cpu_data_t'($random(seed));
            exp_buf[i]   = sd_buff_data;
            wait_cycles(1);
         end
         sd_buff_wr = 1'b0;
         sd_ack     = 1'b0;
         wait_cycles(1);
      end
   endtask

   task automatic read_sector();
      int        trk;
      int        sec;
      int        i;
      cpu_data_t q;
      lba_t      lba;
      trk    = rand_below(80);
      sec    = 1 + rand_below(SPT);
      side_m = cpu_data_t'($random(seed));
      bus_write(FDC_SIDE_ADDR, side_m);
      bus_write(FDC_WD_BASE + 14'd1, cpu_data_t'(trk));
      bus_write(FDC_WD_BASE + 14'd2, cpu_data_t'(sec));
      bus_write(FDC_WD_BASE, 8'h80);
      rnf_m = 1'b0;
      if (layout_m)
         lba = lba_t'(trk * SPT + sec - 1);
      else
         lba = lba_t'((trk * 2 + side_m[0]) * SPT + sec - 1);
      serve_sd_block(lba);
      i = 0;
      bus_read(FDC_STATUS_ADDR, q);
      while (q[7] && i < 10) begin   // drq shows as bit 7 low
         bus_read(FDC_STATUS_ADDR, q);
         i++;
      end
      if (q[7]) begin
         report_problem("drq never rose after the card finished");
      end else begin
         for (i = 0; i < 512; i++) begin
            bus_read(FDC_WD_BASE + 14'd3, q);
            if (q !== exp_buf[i]) report_mismatch($sformatf("data byte %0d", i), q, exp_buf[i]);
         end
         bus_read(FDC_STATUS_ADDR, q);
         if (q !== 8'hBF) report_mismatch("status port after last byte", q, 8'hBF);
         bus_read(FDC_WD_BASE, q);
         if (q !== exp_status()) report_mismatch("wd status after read", q, exp_status());
      end
   endtask

   // read command that must end at once without touching the card
   task automatic expect_rejected(input string why);
      int        i;
      logic      saw;
      cpu_data_t q;
      saw = 1'b0;
      bus_write(FDC_WD_BASE, 8'h80);
      for (i = 0; i < 4; i++) begin
         saw = saw | sd_rd;
         wait_cycles(1);
      end
      if (saw) report_problem({why, ": read command still raised sd_rd"});
      bus_read(FDC_STATUS_ADDR, q);
      if (q !== 8'hBF) report_mismatch({why, ": status port"}, q, 8'hBF);
      bus_read(FDC_WD_BASE, q);
      if (q !== exp_status()) report_mismatch({why, ": wd status"}, q, exp_status());
   endtask

   initial begin
      cpu_data_t q;
      cpu_data_t t;
      int        i;
      int        errs;
      rst_n        = 1'b0;
      addr         = '0;
      wr_data      = '0;
      rd           = 1'b0;
      wr           = 1'b0;
      dev_typ      = DEV_VY0010;
      dev_num      = 4'(DEV_NUM);
      img_mounted  = 1'b0;
      img_size     = '0;
      img_readonly = 1'b0;
      sd_ack       = 1'b0;
      sd_buff_addr = '0;
      sd_buff_data = '0;
      sd_buff_wr   = 1'b0;
      repeat (4) @(posedge cpu_bus);
      #2;
      rst_n = 1'b1;
      wait_cycles(1);

      // --------------------------------------------------
      errs = err_count;
      bus_read(FDC_SIDE_ADDR, q);
      if (q !== 8'h00) report_mismatch("side after reset", q, 8'h00);
      bus_read(FDC_WD_BASE + 14'd1, q);
      if (q !== 8'h00) report_mismatch("track after reset", q, 8'h00);
      bus_read(FDC_STATUS_ADDR, q);
      if (q !== 8'hFF) report_mismatch("status port after reset", q, 8'hFF);
      for (i = 0; i < 4; i++) begin
         side_m = cpu_data_t'($random(seed));
         bus_write(FDC_SIDE_ADDR, side_m);
         bus_read(FDC_SIDE_ADDR, q);
         if (q !== side_m) report_mismatch("side register", q, side_m);
         set_drive(cpu_data_t'($random(seed)));
         bus_read(FDC_DRIVE_ADDR, q);
         if (q !== (drive_m & 8'hFB)) report_mismatch("drive register", q, drive_m & 8'hFB);
      end
      bus_read(FDC_UNUSED_ADDR, q);
      if (q !== 8'hFF) report_mismatch("unused address", q, 8'hFF);
      if (last_rq !== 1'b1) report_mismatch("output_rq on own read", last_rq, 1'b1);
      dev_typ = ~DEV_VY0010;
      bus_read(FDC_SIDE_ADDR, q);
      if (q !== 8'hFF || last_rq !== 1'b0) report_problem("answered a foreign device type");
      dev_typ = DEV_VY0010;
      dev_num = 4'(DEV_NUM + 1);
      bus_read(FDC_SIDE_ADDR, q);
      if (q !== 8'hFF || last_rq !== 1'b0) report_problem("answered a foreign device number");
      dev_num = 4'(DEV_NUM);
      finish_test("register readback", errs);

      // --------------------------------------------------
      errs = err_count;
      for (i = 0; i < 7; i++) begin
         t = (i == 6) ? cpu_data_t'(1 + rand_below(79)) : cpu_data_t'(rand_below(80));
         bus_write(FDC_WD_BASE + 14'd3, t);
         if (i == 6) begin   // last pass restores from a nonzero track and data register
            bus_write(FDC_WD_BASE + 14'd1, t);
            bus_write(FDC_WD_BASE, 8'h00);
            t = 8'h00;
         end else begin
            bus_write(FDC_WD_BASE, 8'h10);
         end
         rnf_m = 1'b0;
         bus_read(FDC_STATUS_ADDR, q);
         if (q[6] !== 1'b0) report_problem("intrq not raised by a type I command");
         bus_read(FDC_WD_BASE + 14'd1, q);
         if (q !== t) report_mismatch("track register", q, t);
         bus_read(FDC_WD_BASE, q);
         if (q !== exp_status()) report_mismatch("wd status", q, exp_status());
         bus_read(FDC_STATUS_ADDR, q);
         if (q[6] !== 1'b1) report_problem("status read did not clear intrq");
      end
      finish_test("restore and seek", errs);

      // --------------------------------------------------
      errs = err_count;
      set_drive(8'h80);
      mount_image(32'h0005_A000, 1'b0);   // exactly at the limit, single sided
      repeat (READS_PER_IMAGE) read_sector();
      mount_image(32'h000B_4000, 1'b0);   // 720K, double sided
      repeat (READS_PER_IMAGE) read_sector();
      finish_test("sector read", errs);

      // --------------------------------------------------
      errs = err_count;
      bus_write(FDC_WD_BASE + 14'd2, 8'd1);
      rnf_m = 1'b0;
      set_drive(8'h00);
      expect_rejected("drive bit 7 clear");
      set_drive(8'h81);
      expect_rejected("drive bit 0 set");
      set_drive(8'h80);
      mount_image(32'h0, 1'b0);
      expect_rejected("no image");
      finish_test("not ready", errs);

      errs = err_count;
      mount_image(32'h000B_4000, 1'b0);
      rnf_m = 1'b1;
      bus_write(FDC_WD_BASE + 14'd2, 8'd0);
      expect_rejected("sector 0");
      for (i = 0; i < 3; i++) begin
         bus_write(FDC_WD_BASE + 14'd2, cpu_data_t'(SPT + 1 + rand_below(255 - SPT)));
         expect_rejected("sector past end of track");
      end
      finish_test("record not found", errs);

      errs = err_count;
      for (i = 0; i < 2; i++) begin
         mount_image(32'h0005_A000, (i == 0));
         bus_read(FDC_WD_BASE, q);
         if (q !== exp_status()) report_mismatch("wd status after mount", q, exp_status());
      end
      finish_test("write protect", errs);

      errs = err_count;
      if (vy0010_fdc_inst.fdc_sector_engine_inst.checker_inst.fail_count != 0)
         report_problem("protocol assertions fired during the run");
      finish_test("protocol assertions", errs);

      $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
      if (fail_tests == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/fdc_bus_pkg.sv
logic/fdc_disk_pkg.sv
logic/fdc_reg_decode.sv
logic/fdc_sector_engine.sv
logic/fdc_read_mux.sv
logic/vy0010_fdc.sv
testbench/vy0010_fdc_checker.sv
testbench/vy0010_fdc_tb.sv

// ==== Bender.yml ====
package:
  name: vy0010_fdc

sources:
  - files:
      - logic/fdc_bus_pkg.sv
      - logic/fdc_disk_pkg.sv
      - logic/fdc_reg_decode.sv
      - logic/fdc_sector_engine.sv
      - logic/fdc_read_mux.sv
      - logic/vy0010_fdc.sv
  - target: test
    files:
      - testbench/vy0010_fdc_checker.sv
      - testbench/vy0010_fdc_tb.sv
